/* all.f */
+incdir+design
design/data_pkg.sv
design/layer_pkg.sv
design/adder_tree_32.sv
design/mul_array.sv
design/reducer.sv
design/psum_engine.sv
verification/tb_psum_engine.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the failure message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_psum_engine \
    -f all.f -o sim_psum_engine > build.log 2>&1 &&
./obj_dir/sim_psum_engine > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation reported errors"; exit 1; } || exit 0

/* verification/tb_psum_engine.sv */
`timescale 1ns/100ps
`include "acc_consts.svh"

module tb_psum_engine;
    import data_pkg::*;
    import layer_pkg::*;

    localparam int OUT_BITS = `PE_ROWS * `PSUM_W;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    act_t        act        [`PE_COLS-1:0];
    wgt_t        weight     [`PE_ROWS-1:0][`PE_COLS-1:0];
    layer_type_e layer_type;
    logic        ipsum_add_en;
    psum_t       ipsum_in   [`PE_ROWS-1:0];
    logic        out_valid;
    psum_t       final_psum [`PE_ROWS-1:0];

    logic [31:0]         lcg_state;
    logic [OUT_BITS-1:0] exp_q [$];             // Expected results in issue order
    int                  due_q [$];             // Cycle on which each result must show
    logic [OUT_BITS-1:0] last_psum      = '0;   // Reset value of final_psum
    int                  cycle          = 0;
    int                  n_sent         = 0;
    int                  value_errors   = 0;
    int                  timing_errors  = 0;
    int                  missing_errors = 0;

    psum_engine psum_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .act          (act),
        .weight       (weight),
        .layer_type   (layer_type),
        .ipsum_add_en (ipsum_add_en),
        .ipsum_in     (ipsum_in),
        .out_valid    (out_valid),
        .final_psum   (final_psum)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];  // Upper half has the better period
    endfunction

    function automatic logic [OUT_BITS-1:0] model_psum(
        input act_t        a  [`PE_COLS-1:0],
        input wgt_t        w  [`PE_ROWS-1:0][`PE_COLS-1:0],
        input layer_type_e lt,
        input logic        add_en,
        input psum_t       ip [`PE_ROWS-1:0]
    );
        logic [31:0]         rows [`PE_ROWS-1:0];
        logic [31:0]         acc;
        logic [OUT_BITS-1:0] result;
        for (int r = 0; r < `PE_ROWS; r++) begin
            rows[r] = '0;
            for (int c = 0; c < `PE_COLS; c++) begin
                rows[r] = rows[r] + 32'(a[c]) * 32'(w[r][c]);
            end
        end
        for (int i = 0; i < `PE_ROWS; i++) begin
            if (lt == LAYER_POINTWISE) begin
                acc = rows[i];
            end else if (i < `GROUP_OUTS) begin
                acc = rows[`GROUP_ROWS*i] + rows[`GROUP_ROWS*i+1] + rows[`GROUP_ROWS*i+2];
            end else begin
                acc = '0;
            end
            if (add_en) acc = acc + 32'(ip[i]);
            result[i*`PSUM_W +: `PSUM_W] = acc[`PSUM_W-1:0];
        end
        return result;
    endfunction

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic clear_inputs();
        in_valid     = 1'b0;
        layer_type   = LAYER_POINTWISE;
        ipsum_add_en = 1'b0;
        for (int r = 0; r < `PE_ROWS; r++) begin
            ipsum_in[r] = '0;
            for (int c = 0; c < `PE_COLS; c++) weight[r][c] = '0;
        end
        for (int c = 0; c < `PE_COLS; c++) act[c] = '0;
    endtask

    task automatic randomize_inputs();
        logic [15:0] bits;
        for (int c = 0; c < `PE_COLS; c++) act[c] = act_t'(lcg_next());
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int c = 0; c < `PE_COLS; c++) weight[r][c] = wgt_t'(lcg_next());
            ipsum_in[r] = lcg_next();
        end
        bits         = lcg_next();
        layer_type   = layer_type_e'(bits[1:0]);  // Unnamed code 3 is included
        ipsum_add_en = bits[2];
    endtask

    task automatic present(input logic valid);
        in_valid = valid;
        if (valid) begin
            exp_q.push_back(model_psum(act, weight, layer_type, ipsum_add_en, ipsum_in));
            due_q.push_back(cycle + 3);  // Sampled next edge, visible one edge after
            n_sent++;
        end
    endtask

    task automatic drive_random(input logic valid);
        @(negedge clk);
        randomize_inputs();
        present(valid);
    endtask

    task automatic drive_saturated(input layer_type_e lt, input logic add_en);
        @(negedge clk);
        for (int c = 0; c < `PE_COLS; c++) act[c] = 8'hFF;
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int c = 0; c < `PE_COLS; c++) weight[r][c] = 8'hFF;
            ipsum_in[r] = 16'hFFFF;
        end
        layer_type   = lt;
        ipsum_add_en = add_en;
        present(1'b1);
    endtask

    // ----------------------------------------
    // Scoreboard
    // ----------------------------------------
    task automatic compare_lanes(input logic [OUT_BITS-1:0] expected);
        psum_t want;
        for (int i = 0; i < `PE_ROWS; i++) begin
            want = expected[i*`PSUM_W +: `PSUM_W];
            assert (final_psum[i] == want) else begin
                value_errors++;
                $display("CHECK FAILED final_psum[%0d] expected 0x%04h actual 0x%04h cycle %0d",
                         i, want, final_psum[i], cycle);
            end
        end
    endtask

    task automatic check_output();
        logic [OUT_BITS-1:0] expected;
        int                  due;
        if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                timing_errors++;
                $display("out_valid was high at cycle %0d with no item in flight", cycle);
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                due      = due_q.pop_front();
                assert (cycle == due) else begin
                    timing_errors++;
                    $display("Result showed at cycle %0d but was due at cycle %0d", cycle, due);
                end
                compare_lanes(expected);
                last_psum = expected;
            end
        end else begin
            if (due_q.size() != 0) begin
                assert (due_q[0] != cycle) else begin
                    timing_errors++;
                    $display("out_valid stayed low at cycle %0d when a result was due", cycle);
                end
            end
            compare_lanes(last_psum);  // Output holds between results
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst_n) check_output();
    end

    initial begin
        int waited;
        lcg_state = 32'd42;
        rst_n     = 1'b0;
        clear_inputs();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (5) drive_random(1'b0);  // Idle with noise on the data inputs

        drive_saturated(LAYER_POINTWISE, 1'b0);
        drive_saturated(LAYER_DEPTHWISE, 1'b1);
        drive_saturated(LAYER_CONV3X3, 1'b0);
        drive_saturated(LAYER_POINTWISE, 1'b1);

        repeat (50) drive_random(1'b1);
        repeat (2) drive_random(1'b0);
        repeat (80) drive_random((lcg_next() % 3) != 0);
        drive_random(1'b0);

        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            missing_errors += exp_q.size();
            $display("Timed out while %0d results were still missing", exp_q.size());
        end

        // Quiet tail, no result may show and the last one must hold
        repeat (4) drive_random(1'b0);

        $display("Errors: value %0d, timing %0d, missing %0d over %0d items",
                 value_errors, timing_errors, missing_errors, n_sent);
        if (value_errors + timing_errors + missing_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* design/psum_engine.sv */
`timescale 1ns/100ps
`include "acc_consts.svh"

module psum_engine (
    input  logic                    clk,
    input  logic                    rst_n,

    // Item entering the pipeline
    input  logic                    in_valid,
    input  data_pkg::act_t          act        [`PE_COLS-1:0],
    input  data_pkg::wgt_t          weight     [`PE_ROWS-1:0][`PE_COLS-1:0],
    input  layer_pkg::layer_type_e  layer_type,
    input  logic                    ipsum_add_en,
    input  data_pkg::psum_t         ipsum_in   [`PE_ROWS-1:0],

    // Result, two cycles after in_valid
    output logic                    out_valid,
    output data_pkg::psum_t         final_psum [`PE_ROWS-1:0]
);
    import data_pkg::*;
    import layer_pkg::*;

    // ----------------------------------------
    // Stage 1 to stage 2
    // ----------------------------------------
    logic        mul_valid;
    product_t    mul_out_matrix [`PE_ROWS-1:0][`PE_COLS-1:0];
    layer_type_e mul_layer_type;
    logic        mul_ipsum_add_en;
    psum_t       mul_ipsum      [`PE_ROWS-1:0];

    // ----------------------------------------
    // Stage 1, multipliers
    // ----------------------------------------
    mul_array mul_array_inst (
        .clk              (clk),
        .rst_n            (rst_n),

        .in_valid         (in_valid),
        .act              (act),
        .weight           (weight),
        .layer_type       (layer_type),
        .ipsum_add_en     (ipsum_add_en),
        .ipsum_in         (ipsum_in),

        .mul_valid        (mul_valid),
        .mul_out_matrix   (mul_out_matrix),
        .mul_layer_type   (mul_layer_type),
        .mul_ipsum_add_en (mul_ipsum_add_en),
        .mul_ipsum        (mul_ipsum)
    );

    // ----------------------------------------
    // Stage 2, reduction
    // ----------------------------------------
    // Controls come from stage 1 so they match the products in flight
    reducer reducer_inst (
        .clk              (clk),
        .rst_n            (rst_n),

        .mul_valid        (mul_valid),
        .layer_type       (mul_layer_type),
        .ipsum_add_en     (mul_ipsum_add_en),
        .mul_out_matrix   (mul_out_matrix),
        .ipsum_out        (mul_ipsum),

        .out_valid        (out_valid),
        .final_psum       (final_psum)
    );

endmodule

/* design/reducer.sv */
`timescale 1ns/100ps
`include "acc_consts.svh"

module reducer (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    mul_valid,
    input  layer_pkg::layer_type_e  layer_type,
    input  logic                    ipsum_add_en,
    input  data_pkg::product_t      mul_out_matrix [`PE_ROWS-1:0][`PE_COLS-1:0],
    input  data_pkg::psum_t         ipsum_out      [`PE_ROWS-1:0],

    output logic                    out_valid,
    output data_pkg::psum_t         final_psum     [`PE_ROWS-1:0]
);
    import data_pkg::*;
    import layer_pkg::*;

    row_sum_t row_sum      [`PE_ROWS-1:0];     // One tree result per row
    row_sum_t group_sum    [`GROUP_OUTS-1:0];  // Three rows folded together
    row_sum_t grouped_sum  [`PE_ROWS-1:0];     // group_sum padded out to full width
    row_sum_t selected_sum [`PE_ROWS-1:0];
    row_sum_t total_sum    [`PE_ROWS-1:0];
    logic     grouped;

    genvar r;

    // ----------------------------------------
    // Row reduction and padding
    // ----------------------------------------
    generate
        for (r = 0; r < `PE_ROWS; r++) begin : gen_row
            adder_tree_32 adder_tree_inst (
                .in  (mul_out_matrix[r]),
                .sum (row_sum[r])
            );

            // Outputs past the last full group carry nothing in 3x3 modes
            if (r < `GROUP_OUTS) begin : gen_group_out
                assign grouped_sum[r] = group_sum[r];
            end else begin : gen_empty_out
                assign grouped_sum[r] = '0;
            end
        end
    endgenerate

    // ----------------------------------------
    // 3-row grouping
    // ----------------------------------------
    // Rows 30 and 31 fall outside every group and are dropped here
    always_comb begin
        for (int g = 0; g < `GROUP_OUTS; g++) begin
            group_sum[g] = '0;
            for (int k = 0; k < `GROUP_ROWS; k++) begin
                group_sum[g] = group_sum[g] + row_sum[g*`GROUP_ROWS + k];
            end
        end
    end

    // ----------------------------------------
    // Layer mux and incoming partial sum
    // ----------------------------------------
    // The unnamed fourth code reduces like depthwise and 3x3
    assign grouped = (layer_type != LAYER_POINTWISE);

    always_comb begin
        for (int i = 0; i < `PE_ROWS; i++) begin
            selected_sum[i] = grouped ? grouped_sum[i] : row_sum[i];

            if (ipsum_add_en) begin
                total_sum[i] = selected_sum[i] + row_sum_t'(ipsum_out[i]);
            end else begin
                total_sum[i] = selected_sum[i];
            end
        end
    end

    // ----------------------------------------
    // Stage 2 register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mul_valid;
        end
    end

    // Holds the last result while no item is in stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PE_ROWS; i++) begin
                final_psum[i] <= '0;
            end
        end else if (mul_valid) begin
            for (int i = 0; i < `PE_ROWS; i++) begin
                final_psum[i] <= total_sum[i][`PSUM_W-1:0];  // Keep only the low bits
            end
        end
    end

endmodule

/* design/mul_array.sv */
`timescale 1ns/100ps
`include "acc_consts.svh"

module mul_array (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    input  data_pkg::act_t          act            [`PE_COLS-1:0],
    input  data_pkg::wgt_t          weight         [`PE_ROWS-1:0][`PE_COLS-1:0],
    input  layer_pkg::layer_type_e  layer_type,
    input  logic                    ipsum_add_en,
    input  data_pkg::psum_t         ipsum_in       [`PE_ROWS-1:0],

    output logic                    mul_valid,
    output data_pkg::product_t      mul_out_matrix [`PE_ROWS-1:0][`PE_COLS-1:0],
    output layer_pkg::layer_type_e  mul_layer_type,
    output logic                    mul_ipsum_add_en,
    output data_pkg::psum_t         mul_ipsum      [`PE_ROWS-1:0]
);
    import data_pkg::*;
    import layer_pkg::*;

    product_t product [`PE_ROWS-1:0][`PE_COLS-1:0];

    // ----------------------------------------
    // Multipliers, one per row and lane
    // ----------------------------------------
    always_comb begin
        for (int r = 0; r < `PE_ROWS; r++) begin
            for (int c = 0; c < `PE_COLS; c++) begin
                // Widen first so the multiply runs at product width
                product[r][c] = product_t'(act[c]) * product_t'(weight[r][c]);
            end
        end
    end

    // ----------------------------------------
    // Stage 1 register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_valid <= 1'b0;
        end else begin
            mul_valid <= in_valid;  // One cycle behind the input strobe
        end
    end

    // Side-band fields ride with their products so stage 2 sees one item
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_layer_type   <= LAYER_POINTWISE;
            mul_ipsum_add_en <= 1'b0;
            for (int r = 0; r < `PE_ROWS; r++) begin
                mul_ipsum[r] <= '0;
                for (int c = 0; c < `PE_COLS; c++) begin
                    mul_out_matrix[r][c] <= '0;
                end
            end
        end else if (in_valid) begin
            mul_layer_type   <= layer_type;
            mul_ipsum_add_en <= ipsum_add_en;
            for (int r = 0; r < `PE_ROWS; r++) begin
                mul_ipsum[r] <= ipsum_in[r];
                for (int c = 0; c < `PE_COLS; c++) begin
                    mul_out_matrix[r][c] <= product[r][c];
                end
            end
        end
    end

endmodule

/* design/adder_tree_32.sv */
`timescale 1ns/100ps
`include "acc_consts.svh"

module adder_tree_32 (
    input  data_pkg::product_t in [`PE_COLS-1:0],
    output data_pkg::row_sum_t sum
);
    import data_pkg::*;

    // Every level is kept at full sum width so no carry is lost
    row_sum_t lvl1 [`PE_COLS/2-1:0];
    row_sum_t lvl2 [`PE_COLS/4-1:0];
    row_sum_t lvl3 [`PE_COLS/8-1:0];
    row_sum_t lvl4 [`PE_COLS/16-1:0];

    genvar i1;
    genvar i2;
    genvar i3;
    genvar i4;

    // ----------------------------------------
    // Level 1 zero-extends the products
    // ----------------------------------------
    generate
        for (i1 = 0; i1 < `PE_COLS/2; i1++) begin : gen_lvl1
            assign lvl1[i1] = row_sum_t'(in[2*i1]) + row_sum_t'(in[2*i1+1]);
        end
    endgenerate

    // ----------------------------------------
    // Levels 2 to 4
    // ----------------------------------------
    generate
        for (i2 = 0; i2 < `PE_COLS/4; i2++) begin : gen_lvl2
            assign lvl2[i2] = lvl1[2*i2] + lvl1[2*i2+1];
        end

        for (i3 = 0; i3 < `PE_COLS/8; i3++) begin : gen_lvl3
            assign lvl3[i3] = lvl2[2*i3] + lvl2[2*i3+1];
        end

        for (i4 = 0; i4 < `PE_COLS/16; i4++) begin : gen_lvl4
            assign lvl4[i4] = lvl3[2*i4] + lvl3[2*i4+1];
        end
    endgenerate

    assign sum = lvl4[0] + lvl4[1];  // Level 5, the single root adder

endmodule

/* design/layer_pkg.sv */
package layer_pkg;

    // Layer kind that selects how row sums are combined
    // Code 2'b11 has no name and reduces like the 3x3 kinds
    typedef enum logic [1:0] {
        LAYER_POINTWISE = 2'b00,    // One output per row
        LAYER_DEPTHWISE = 2'b01,
        LAYER_CONV3X3   = 2'b10
    } layer_type_e;

endpackage

/* design/data_pkg.sv */
`include "acc_consts.svh"

package data_pkg;

    // All lanes are unsigned
    typedef logic [`ACT_W-1:0]          act_t;
    typedef logic [`WGT_W-1:0]          wgt_t;

    // Full 8x8 product, no rounding
    typedef logic [`ACT_W+`WGT_W-1:0]   product_t;

    typedef logic [`PSUM_W-1:0]         psum_t;     // Partial sum as it leaves the engine
    typedef logic [`SUM_W-1:0]          row_sum_t;  // Adder tree result before truncation

endpackage

/* design/acc_consts.svh */
`ifndef ACC_CONSTS_SVH
`define ACC_CONSTS_SVH

// ----------------------------------------
// Array geometry
// ----------------------------------------
`define PE_ROWS     32      // Rows of the PE array, one output each
`define PE_COLS     32      // Activation lanes per row

// 3x3 layers fold three neighbouring rows into one output
`define GROUP_ROWS  3
`define GROUP_OUTS  10      // Only 30 of the 32 rows fit into full groups

// ----------------------------------------
// Lane widths
// ----------------------------------------
`define ACT_W       8
`define WGT_W       8
`define PSUM_W      16
`define SUM_W       32      // Wide enough for a whole row plus grouping

`endif
